/* logic/rv_pkg.sv */
package rv_pkg;

	// data, address and instruction word.
	typedef logic [31:0] word_t;

	// rv32e register index, 16 registers.
	typedef logic [3:0] reg_idx_t;

	localparam int kind_count = 9;

	// one-hot decoded instruction kind.
	typedef logic [kind_count-1:0] inst_kind_t;

	localparam int kind_lui   = 0;
	localparam int kind_auipc = 1;
	localparam int kind_jal   = 2;
	localparam int kind_jalr  = 3;
	localparam int kind_beq   = 4;
	localparam int kind_lw    = 5;
	localparam int kind_sw    = 6;
	localparam int kind_addi  = 7;
	localparam int kind_add   = 8;

endpackage

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic          clock,
	input  logic          reset,
	input  logic          fetch_ready,
	input  logic          redirect,
	input  rv_pkg::word_t redirect_pc,
	output rv_pkg::word_t imem_addr,
	output rv_pkg::word_t fetch_pc,
	output logic          fetch_valid
);
	import rv_pkg::*;

	word_t pc_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q        <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b1;
			// a redirect wins over a normal advance.
			if (redirect) begin
				pc_q <= redirect_pc;
			end else if (fetch_valid && fetch_ready) begin
				pc_q <= pc_q + 32'd4;
			end
		end
	end

	assign imem_addr = pc_q;
	assign fetch_pc  = pc_q;

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic             clock,
	input  logic             reset,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	output rv_pkg::word_t    rdata1,
	output rv_pkg::word_t    rdata2,
	input  logic             wen,
	input  rv_pkg::reg_idx_t waddr,
	input  rv_pkg::word_t    wdata
);
	import rv_pkg::*;

	localparam int reg_count = 2 ** $bits(reg_idx_t);

	word_t regs [reg_count];

	// x0 is cleared by reset and never written, so it reads as zero.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[rs1];
	assign rdata2 = regs[rs2];

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic               clock,
	input  logic               reset,
	input  rv_pkg::word_t      inst,
	input  rv_pkg::word_t      fetch_pc,
	input  logic               fetch_valid,
	output logic               fetch_ready,
	output rv_pkg::reg_idx_t   rs1,
	output rv_pkg::reg_idx_t   rs2,
	input  rv_pkg::word_t      src1,
	input  rv_pkg::word_t      src2,
	input  rv_pkg::reg_idx_t   exu_rd,
	input  logic               exu_reg_wen,
	input  logic               wb_valid,
	input  logic               exu_ready,
	input  logic               redirect,
	input  rv_pkg::word_t      wb_val,
	output logic               exu_valid,
	output rv_pkg::word_t      pc,
	output rv_pkg::inst_kind_t kind,
	output logic [2:0]         funct3,
	output rv_pkg::reg_idx_t   rd,
	output logic               reg_wen,
	output rv_pkg::word_t      imm,
	output rv_pkg::word_t      op_a,
	output rv_pkg::word_t      op_b
);
	import rv_pkg::*;

	localparam int fmt_r = 0;
	localparam int fmt_i = 1;
	localparam int fmt_s = 2;
	localparam int fmt_b = 3;
	localparam int fmt_u = 4;
	localparam int fmt_j = 5;

	logic [4:0] opcode;
	inst_kind_t kind_d;
	logic [5:0] fmt;
	reg_idx_t   rd_d;
	logic       reg_wen_d;
	word_t      imm_d;
	logic       need_rs1;
	logic       need_rs2;
	logic       rs1_exu_hit;
	logic       rs2_exu_hit;
	logic       rs1_dec_hit;
	logic       rs2_dec_hit;
	logic       raw_hazard;
	logic       accept;
	word_t      fwd1;
	word_t      fwd2;

	// rv32e keeps only the low four bits of each register field.
	assign opcode = inst[6:2];
	assign rs1    = inst[18:15];
	assign rs2    = inst[23:20];
	assign rd_d   = inst[10:7];

	always_comb begin
		kind_d = '0;
		if (inst[1:0] == 2'b11) begin
			case (opcode)
				5'b01101: kind_d[kind_lui]   = 1'b1;
				5'b00101: kind_d[kind_auipc] = 1'b1;
				5'b11011: kind_d[kind_jal]   = 1'b1;
				5'b11001: kind_d[kind_jalr]  = 1'b1;
				5'b11000: kind_d[kind_beq]   = 1'b1;
				5'b00000: kind_d[kind_lw]    = 1'b1;
				5'b01000: kind_d[kind_sw]    = 1'b1;
				5'b00100: kind_d[kind_addi]  = 1'b1;
				5'b01100: kind_d[kind_add]   = 1'b1;
				default: kind_d = '0;
			endcase
		end
	end

	assign fmt[fmt_r] = kind_d[kind_add];
	assign fmt[fmt_i] = kind_d[kind_jalr] | kind_d[kind_lw] | kind_d[kind_addi];
	assign fmt[fmt_s] = kind_d[kind_sw];
	assign fmt[fmt_b] = kind_d[kind_beq];
	assign fmt[fmt_u] = kind_d[kind_lui] | kind_d[kind_auipc];
	assign fmt[fmt_j] = kind_d[kind_jal];

	// writes to x0 are dropped here, so later stages never see them.
	assign reg_wen_d = (fmt[fmt_r] | fmt[fmt_i] | fmt[fmt_u] | fmt[fmt_j]) & (rd_d != '0);

	always_comb begin
		imm_d = '0;
		if (fmt[fmt_i]) begin
			imm_d = {{20{inst[31]}}, inst[31:20]};
		end else if (fmt[fmt_s]) begin
			imm_d = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		end else if (fmt[fmt_b]) begin
			imm_d = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		end else if (fmt[fmt_u]) begin
			imm_d = {inst[31:12], 12'b0};
		end else if (fmt[fmt_j]) begin
			imm_d = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		end
	end

	assign need_rs2 = fmt[fmt_r] | fmt[fmt_s] | fmt[fmt_b];
	assign need_rs1 = need_rs2 | fmt[fmt_i];

	// the instruction in execute either retires now or is still pending.
	assign rs1_exu_hit = exu_reg_wen & need_rs1 & (exu_rd == rs1);
	assign rs2_exu_hit = exu_reg_wen & need_rs2 & (exu_rd == rs2);
	assign rs1_dec_hit = exu_valid & reg_wen & need_rs1 & (rd == rs1);
	assign rs2_dec_hit = exu_valid & reg_wen & need_rs2 & (rd == rs2);

	// a retiring producer forwards, a pending one stalls.
	assign raw_hazard = (~wb_valid & (rs1_exu_hit | rs2_exu_hit)) | rs1_dec_hit | rs2_dec_hit;

	assign fetch_ready = ~raw_hazard & (exu_ready | ~exu_valid);
	assign accept      = fetch_valid & fetch_ready;

	assign fwd1 = rs1_exu_hit ? wb_val : src1;
	assign fwd2 = rs2_exu_hit ? wb_val : src2;

	always_ff @(posedge clock) begin
		if (reset) begin
			exu_valid <= 1'b0;
		end else begin
			exu_valid <= ((exu_valid & ~exu_ready) | accept) & ~redirect;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			pc      <= fetch_pc;
			kind    <= kind_d;
			funct3  <= inst[14:12];
			rd      <= rd_d;
			reg_wen <= reg_wen_d;
			imm     <= imm_d;
			op_a    <= fwd1;
			op_b    <= fwd2;
		end
	end

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
	parameter int ram_words = 64
) (
	input  logic                         clock,
	input  logic                         wen,
	input  logic [$clog2(ram_words)-1:0] addr,
	input  rv_pkg::word_t                wdata,
	output rv_pkg::word_t                rdata
);
	import rv_pkg::*;

	word_t mem [ram_words];

	always_ff @(posedge clock) begin
		if (wen) begin
			mem[addr] <= wdata;
		end
	end

	// read data appears one cycle after the address.
	always_ff @(posedge clock) begin
		rdata <= mem[addr];
	end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage #(
	parameter int ram_words = 64
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               exu_valid,
	output logic               exu_ready,
	input  rv_pkg::word_t      pc,
	input  rv_pkg::inst_kind_t kind,
	input  logic [2:0]         funct3,
	input  rv_pkg::reg_idx_t   rd,
	input  logic               reg_wen,
	input  rv_pkg::word_t      imm,
	input  rv_pkg::word_t      op_a,
	input  rv_pkg::word_t      op_b,
	output rv_pkg::reg_idx_t   exu_rd,
	output logic               exu_reg_wen,
	output logic               wb_valid,
	output rv_pkg::reg_idx_t   wb_rd,
	output rv_pkg::word_t      wb_val,
	output logic               redirect,
	output rv_pkg::word_t      redirect_pc
);
	import rv_pkg::*;

	localparam int ram_aw = $clog2(ram_words);

	typedef enum logic {
		st_idle,
		st_mem_wait
	} ex_state_t;

	ex_state_t         state;
	logic              ex_valid;
	word_t             ex_pc;
	inst_kind_t        ex_kind;
	logic [2:0]        ex_funct3;
	reg_idx_t          ex_rd;
	logic              ex_reg_wen;
	word_t             ex_imm;
	word_t             ex_op_a;
	word_t             ex_op_b;
	logic              is_mem;
	logic              mem_first;
	logic              taken;
	word_t             sum;
	word_t             link;
	word_t             target;
	word_t             word_index;
	word_t             ram_rdata;
	logic [ram_aw-1:0] ram_addr;
	logic              ram_wen;

	// the instruction is held while exu_ready is low.
	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else if (exu_ready) begin
			ex_valid <= exu_valid & ~redirect;
		end
	end

	always_ff @(posedge clock) begin
		if (exu_valid && exu_ready) begin
			ex_pc      <= pc;
			ex_kind    <= kind;
			ex_funct3  <= funct3;
			ex_rd      <= rd;
			ex_reg_wen <= reg_wen;
			ex_imm     <= imm;
			ex_op_a    <= op_a;
			ex_op_b    <= op_b;
		end
	end

	assign is_mem    = ex_kind[kind_lw] | ex_kind[kind_sw];
	assign mem_first = ex_valid & is_mem & (state == st_idle);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:     state <= mem_first ? st_mem_wait : st_idle;
				st_mem_wait: state <= st_idle;
				default:     state <= st_idle;
			endcase
		end
	end

	// sum doubles as the load/store address and the jalr target.
	assign sum    = ex_op_a + (ex_kind[kind_add] ? ex_op_b : ex_imm);
	assign link   = ex_pc + 32'd4;
	assign target = ex_pc + ex_imm;

	assign word_index = sum >> 2;
	assign ram_addr   = ram_aw'(word_index % ram_words);
	assign ram_wen    = mem_first & ex_kind[kind_sw];

	data_ram #(
		.ram_words(ram_words)
	) u_data_ram (
		.clock(clock),
		.wen  (ram_wen),
		.addr (ram_addr),
		.wdata(ex_op_b),
		.rdata(ram_rdata)
	);

	assign exu_ready = ~mem_first;
	assign wb_valid  = ex_valid & (~is_mem | (state == st_mem_wait));

	assign exu_rd      = ex_rd;
	assign exu_reg_wen = ex_valid & ex_reg_wen;
	assign wb_rd       = ex_rd;

	always_comb begin
		if (ex_kind[kind_lui]) begin
			wb_val = ex_imm;
		end else if (ex_kind[kind_auipc]) begin
			wb_val = target;
		end else if (ex_kind[kind_jal] | ex_kind[kind_jalr]) begin
			wb_val = link;
		end else if (ex_kind[kind_lw]) begin
			wb_val = ram_rdata;
		end else begin
			wb_val = sum;
		end
	end

	// only funct3 000 is beq, other branch forms fall through.
	assign taken       = ex_kind[kind_beq] & (ex_funct3 == 3'b000) & (ex_op_a == ex_op_b);
	assign redirect    = wb_valid & (ex_kind[kind_jal] | ex_kind[kind_jalr] | taken);
	assign redirect_pc = ex_kind[kind_jalr] ? {sum[31:1], 1'b0} : target;

endmodule

/* logic/core_top.sv */
`timescale 1ns/1ps

module core_top #(
	parameter int ram_words = 64
) (
	input  logic             clock,
	input  logic             reset,
	output rv_pkg::word_t    imem_addr,
	input  rv_pkg::word_t    imem_data,
	output logic             retire_valid,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t    retire_val
);
	import rv_pkg::*;

	word_t      fetch_pc;
	logic       fetch_valid;
	logic       fetch_ready;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	word_t      src1;
	word_t      src2;
	logic       exu_valid;
	logic       exu_ready;
	word_t      dec_pc;
	inst_kind_t kind;
	logic [2:0] funct3;
	reg_idx_t   rd;
	logic       reg_wen;
	word_t      imm;
	word_t      op_a;
	word_t      op_b;
	reg_idx_t   exu_rd;
	logic       exu_reg_wen;
	logic       wb_valid;
	reg_idx_t   wb_rd;
	word_t      wb_val;
	logic       wb_wen;
	logic       redirect;
	word_t      redirect_pc;

	fetch_unit u_fetch (
		.clock      (clock),
		.reset      (reset),
		.fetch_ready(fetch_ready),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.imem_addr  (imem_addr),
		.fetch_pc   (fetch_pc),
		.fetch_valid(fetch_valid)
	);

	decode_stage u_decode (
		.clock      (clock),
		.reset      (reset),
		.inst       (imem_data),
		.fetch_pc   (fetch_pc),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.rs1        (rs1),
		.rs2        (rs2),
		.src1       (src1),
		.src2       (src2),
		.exu_rd     (exu_rd),
		.exu_reg_wen(exu_reg_wen),
		.wb_valid   (wb_valid),
		.exu_ready  (exu_ready),
		.redirect   (redirect),
		.wb_val     (wb_val),
		.exu_valid  (exu_valid),
		.pc         (dec_pc),
		.kind       (kind),
		.funct3     (funct3),
		.rd         (rd),
		.reg_wen    (reg_wen),
		.imm        (imm),
		.op_a       (op_a),
		.op_b       (op_b)
	);

	// stores and no-ops retire without a register write.
	assign wb_wen = wb_valid & exu_reg_wen;

	reg_file u_regs (
		.clock (clock),
		.reset (reset),
		.rs1   (rs1),
		.rs2   (rs2),
		.rdata1(src1),
		.rdata2(src2),
		.wen   (wb_wen),
		.waddr (wb_rd),
		.wdata (wb_val)
	);

	execute_stage #(
		.ram_words(ram_words)
	) u_execute (
		.clock      (clock),
		.reset      (reset),
		.exu_valid  (exu_valid),
		.exu_ready  (exu_ready),
		.pc         (dec_pc),
		.kind       (kind),
		.funct3     (funct3),
		.rd         (rd),
		.reg_wen    (reg_wen),
		.imm        (imm),
		.op_a       (op_a),
		.op_b       (op_b),
		.exu_rd     (exu_rd),
		.exu_reg_wen(exu_reg_wen),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_val     (wb_val),
		.redirect   (redirect),
		.redirect_pc(redirect_pc)
	);

	assign retire_valid = wb_wen;
	assign retire_rd    = wb_rd;
	assign retire_val   = wb_val;

endmodule

/* sim/core_chk.sv */
`timescale 1ns/1ps

module core_chk (
	input logic               clock,
	input logic               reset,
	input logic               exu_valid,
	input logic               exu_ready,
	input logic               redirect,
	input logic               fetch_ready,
	input logic               raw_hazard,
	input rv_pkg::word_t      pc,
	input rv_pkg::inst_kind_t kind,
	input logic [2:0]         funct3,
	input rv_pkg::reg_idx_t   rd,
	input logic               reg_wen,
	input rv_pkg::word_t      imm,
	input rv_pkg::word_t      op_a,
	input rv_pkg::word_t      op_b
);

	int assert_fails = 0;

	// a blocked decode output must hold every field.
	held_stable: assert property (@(posedge clock) disable iff (reset)
		exu_valid && !exu_ready |=> exu_valid && $stable(pc) && $stable(kind)
			&& $stable(funct3) && $stable(rd) && $stable(reg_wen) && $stable(imm)
			&& $stable(op_a) && $stable(op_b))
		else begin
			$error("decode output changed while execute was not ready");
			assert_fails = assert_fails + 1;
		end

	squash_on_redirect: assert property (@(posedge clock) disable iff (reset)
		redirect |=> !exu_valid)
		else begin
			$error("decode output still valid after a redirect");
			assert_fails = assert_fails + 1;
		end

	no_accept_on_hazard: assert property (@(posedge clock) disable iff (reset)
		raw_hazard |-> !fetch_ready)
		else begin
			$error("fetch_ready high during a register hazard");
			assert_fails = assert_fails + 1;
		end

endmodule

bind decode_stage core_chk u_chk (
	.clock      (clock),
	.reset      (reset),
	.exu_valid  (exu_valid),
	.exu_ready  (exu_ready),
	.redirect   (redirect),
	.fetch_ready(fetch_ready),
	.raw_hazard (raw_hazard),
	.pc         (pc),
	.kind       (kind),
	.funct3     (funct3),
	.rd         (rd),
	.reg_wen    (reg_wen),
	.imm        (imm),
	.op_a       (op_a),
	.op_b       (op_b)
);

/* sim/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
	import rv_pkg::*;

	localparam logic [6:0] op_lui   = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal   = 7'b1101111;
	localparam logic [6:0] op_jalr  = 7'b1100111;
	localparam logic [6:0] op_beq   = 7'b1100011;
	localparam logic [6:0] op_lw    = 7'b0000011;
	localparam logic [6:0] op_sw    = 7'b0100011;
	localparam logic [6:0] op_addi  = 7'b0010011;
	localparam logic [6:0] op_add   = 7'b0110011;

	// addi x0, x0, 0.
	localparam word_t nop = 32'h0000_0013;

	logic     clock = 1'b0;
	logic     reset = 1'b1;
	word_t    imem_addr;
	word_t    imem_data = nop;
	logic     retire_valid;
	reg_idx_t retire_rd;
	word_t    retire_val;

	word_t    rom [$];
	string    exp_name [$];
	reg_idx_t exp_rd [$];
	word_t    exp_val [$];
	logic     test_bad;
	int       tests_done = 0;
	int       cycle_count = 0;
	int       cycle_limit = 1000;

	core_top #(
		.ram_words(64)
	) dut0 (
		.clock       (clock),
		.reset       (reset),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.retire_valid(retire_valid),
		.retire_rd   (retire_rd),
		.retire_val  (retire_val)
	);

	always #50 clock = ~clock;

	function automatic word_t r_type(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		return {7'b0, 1'b0, rs2, 1'b0, rs1, 3'b000, 1'b0, rd, op_add};
	endfunction

	function automatic word_t i_type(logic [6:0] opcode, logic [2:0] funct3, reg_idx_t rd,
			reg_idx_t rs1, logic [11:0] imm);
		return {imm, 1'b0, rs1, funct3, 1'b0, rd, opcode};
	endfunction

	function automatic word_t s_type(reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
		return {imm[11:5], 1'b0, rs2, 1'b0, rs1, 3'b010, imm[4:0], op_sw};
	endfunction

	function automatic word_t b_type(reg_idx_t rs1, reg_idx_t rs2, logic [12:0] imm);
		return {imm[12], imm[10:5], 1'b0, rs2, 1'b0, rs1, 3'b000, imm[4:1], imm[11], op_beq};
	endfunction

	function automatic word_t u_type(logic [6:0] opcode, reg_idx_t rd, logic [19:0] imm);
		return {imm, 1'b0, rd, opcode};
	endfunction

	function automatic word_t j_type(reg_idx_t rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, op_jal};
	endfunction

	// addresses past the program read as no-ops.
	function automatic word_t rom_read(word_t addr);
		int unsigned idx;
		idx = addr[31:2];
		if (idx < rom.size()) begin
			return rom[idx];
		end
		return nop;
	endfunction

	always @(negedge clock) begin
		imem_data <= rom_read(imem_addr);
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("error: retirement stopped early, %0d of %0d entries seen in %0d cycles",
				tests_done, exp_name.size(), cycle_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic expect_retire(string name, reg_idx_t rd, word_t val);
		exp_name.push_back(name);
		exp_rd.push_back(rd);
		exp_val.push_back(val);
	endtask

	task automatic check_reg(string name, reg_idx_t expected, reg_idx_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s rd: expected x%0d, actual x%0d", name, expected, actual);
			test_bad = 1'b1;
		end
	endtask

	task automatic check_val(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s value: expected %08h, actual %08h", name, expected, actual);
			test_bad = 1'b1;
		end
	endtask

	task automatic build_program();
		rom.push_back(u_type(op_lui, 4'd1, 20'h12345));
		rom.push_back(u_type(op_auipc, 4'd2, 20'h00001));
		rom.push_back(i_type(op_addi, 3'b000, 4'd3, 4'd0, 12'd5));
		rom.push_back(i_type(op_addi, 3'b000, 4'd3, 4'd3, 12'd7));
		rom.push_back(r_type(4'd4, 4'd3, 4'd3));
		rom.push_back(r_type(4'd5, 4'd4, 4'd1));
		rom.push_back(i_type(op_addi, 3'b000, 4'd6, 4'd0, 12'h040));
		rom.push_back(s_type(4'd6, 4'd5, 12'd8));
		rom.push_back(i_type(op_lw, 3'b010, 4'd7, 4'd6, 12'd8));
		rom.push_back(r_type(4'd8, 4'd7, 4'd3));
		rom.push_back(i_type(op_addi, 3'b000, 4'd0, 4'd3, 12'd1));
		rom.push_back(r_type(4'd9, 4'd0, 4'd3));
		// taken branch at pc 48 to pc 60.
		rom.push_back(b_type(4'd3, 4'd3, 13'd12));
		rom.push_back(i_type(op_addi, 3'b000, 4'd10, 4'd0, 12'd99));
		rom.push_back(i_type(op_addi, 3'b000, 4'd10, 4'd0, 12'd98));
		// jump at pc 60 to pc 72.
		rom.push_back(j_type(4'd11, 21'd12));
		rom.push_back(i_type(op_addi, 3'b000, 4'd12, 4'd0, 12'd1));
		rom.push_back(i_type(op_addi, 3'b000, 4'd12, 4'd0, 12'd2));
		rom.push_back(i_type(op_addi, 3'b000, 4'd13, 4'd0, 12'd100));
		// jump at pc 76 to 100 + 12.
		rom.push_back(i_type(op_jalr, 3'b000, 4'd14, 4'd13, 12'd12));
		for (int i = 0; i < 8; i++) begin
			rom.push_back(i_type(op_addi, 3'b000, 4'd15, 4'd0, 12'hfff));
		end
		rom.push_back(i_type(op_addi, 3'b000, 4'd15, 4'd9, 12'd3));
		rom.push_back(r_type(4'd1, 4'd15, 4'd15));
		rom.push_back(r_type(4'd10, 4'd10, 4'd2));
		rom.push_back(r_type(4'd12, 4'd12, 4'd0));
	endtask

	task automatic build_trace();
		expect_retire("lui", 4'd1, 32'h1234_5000);
		expect_retire("auipc", 4'd2, 32'h0000_1004);
		expect_retire("addi", 4'd3, 32'd5);
		expect_retire("addi chain", 4'd3, 32'd12);
		expect_retire("add chain", 4'd4, 32'd24);
		expect_retire("add forward", 4'd5, 32'h1234_5018);
		expect_retire("addi base", 4'd6, 32'h0000_0040);
		expect_retire("lw after sw", 4'd7, 32'h1234_5018);
		expect_retire("add after lw", 4'd8, 32'h1234_5024);
		expect_retire("x0 read", 4'd9, 32'd12);
		expect_retire("jal link", 4'd11, 32'd64);
		expect_retire("jalr base", 4'd13, 32'd100);
		expect_retire("jalr link", 4'd14, 32'd80);
		expect_retire("jalr target", 4'd15, 32'd15);
		expect_retire("add after target", 4'd1, 32'd30);
		expect_retire("beq squash", 4'd10, 32'h0000_1004);
		expect_retire("jal squash", 4'd12, 32'd0);
	endtask

	initial begin
		int passed;
		int failed;
		int extra;
		int chk_fails;
		passed = 0;
		failed = 0;
		extra = 0;
		chk_fails = 0;
		reset = 1'b1;
		build_program();
		build_trace();
		cycle_limit = 4 * rom.size() + 20;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (int t = 0; t < exp_name.size(); t++) begin
			@(negedge clock);
			while (!retire_valid) begin
				@(negedge clock);
			end
			test_bad = 1'b0;
			check_reg(exp_name[t], exp_rd[t], retire_rd);
			check_val(exp_name[t], exp_val[t], retire_val);
			tests_done = tests_done + 1;
			if (test_bad) begin
				failed = failed + 1;
				$display("test %0d %s: failed", t, exp_name[t]);
			end else begin
				passed = passed + 1;
				$display("test %0d %s: ok", t, exp_name[t]);
			end
		end

		// nothing past the trace may retire.
		repeat (8) begin
			@(negedge clock);
			if (retire_valid) begin
				$display("error: unexpected retirement of x%0d with value %08h",
					retire_rd, retire_val);
				extra = extra + 1;
			end
		end

		chk_fails = dut0.u_decode.u_chk.assert_fails;
		$display("tests run %0d, passed %0d, failed %0d, unexpected retirements %0d, %s %0d",
			tests_done, passed, failed, extra, "assertion failures", chk_fails);
		if (failed == 0 && extra == 0 && chk_fails == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/data_ram.sv
logic/execute_stage.sv
logic/core_top.sv
sim/core_chk.sv
sim/core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/fetch_unit.sv
  - logic/reg_file.sv
  - logic/decode_stage.sv
  - logic/data_ram.sv
  - logic/execute_stage.sv
  - logic/core_top.sv
  - target: simulation
    files:
      - sim/core_chk.sv
      - sim/core_tb.sv
